//--- src/vmpeg_bus_pkg.sv
package vmpeg_bus_pkg;
    // CPU bus, address runs [ADDR_W:1]
    localparam int ADDR_W = 23;
    localparam int DATA_W = 16;

    // Word addresses, compared against address[15:1]
    localparam logic [14:0] REG_TIMECODE_HI = 15'h202C;
    localparam logic [14:0] REG_TIMECODE_LO = 15'h202D;
    localparam logic [14:0] REG_TMPREF      = 15'h202E;
    localparam logic [14:0] REG_IER         = 15'h2030;
    localparam logic [14:0] REG_ISR         = 15'h2031;
    localparam logic [14:0] REG_TCNT        = 15'h2032;
    localparam logic [14:0] REG_TRLD        = 15'h2057;
    localparam logic [14:0] REG_SYSCMD      = 15'h2060;
    localparam logic [14:0] REG_IVEC        = 15'h206E;
    localparam logic [14:0] REG_XFER        = 15'h206F;

    localparam logic [DATA_W-1:0] SYSCMD_DMA_START = 16'h8000;
    // Compare value after reset, roughly a 10 ms period
    localparam logic [DATA_W-1:0] TCNT_RESET = 16'd55;

    typedef struct packed {
        logic [6:0] reserved_hi;
        logic       tim;
        logic [4:0] reserved_lo;
        logic       pic;
        logic       gop;
        logic       seq;
    } interrupt_flags_s;

    typedef union packed {
        logic [DATA_W-1:0] word;
        interrupt_flags_s  flags;
    } interrupt_word_u;
endpackage

//--- src/vmpeg_stream_pkg.sv
package vmpeg_stream_pkg;
    // Start code 00 00 01 xx
    localparam logic [7:0] START_PREFIX_ZERO = 8'h00;
    localparam logic [7:0] START_PREFIX_ONE  = 8'h01;
    localparam logic [7:0] CODE_SEQ          = 8'hB3;
    localparam logic [7:0] CODE_GOP          = 8'hB8;
    localparam logic [7:0] CODE_PIC          = 8'h00;

    // Header bytes read after the code byte
    localparam int SEQ_HDR_BYTES = 1;
    localparam int GOP_HDR_BYTES = 4;
    localparam int PIC_HDR_BYTES = 4;

    // Parser states
    localparam logic [2:0] PS_IDLE  = 3'd0;
    localparam logic [2:0] PS_ZERO1 = 3'd1;
    localparam logic [2:0] PS_ZERO2 = 3'd2;
    localparam logic [2:0] PS_CODE  = 3'd3;
    localparam logic [2:0] PS_SEQ   = 3'd4;
    localparam logic [2:0] PS_GOP   = 3'd5;
    localparam logic [2:0] PS_PIC   = 3'd6;

    localparam int TMPREF_W = 10;

    typedef struct packed {
        logic        seq;
        logic        gop;
        logic        pic;
        logic [15:0] tmpref;
        logic [31:0] timecode;
    } header_event_s;

    localparam int QUEUE_DEPTH    = 64;
    localparam int QUEUE_PTR_W    = $clog2(QUEUE_DEPTH);
    localparam int BYTE_BUF_DEPTH = 64;
    localparam int BYTE_BUF_PTR_W = $clog2(BYTE_BUF_DEPTH);

    // 30 MHz down to the 45 kHz tick
    localparam int                    DCLK_CNT_W   = 10;
    localparam logic [DCLK_CNT_W-1:0] DCLK_DIVIDER = 10'd667;
    localparam int                    TIMER_PRESCALE_BITS = 3;
endpackage

//--- src/header_event_if.sv
`timescale 1ns/10ps

interface header_event_if
    import vmpeg_stream_pkg::*;
();
    // One-cycle strobe, no back-pressure
    logic          write;
    header_event_s entry;

    modport producer (
        output write,
        output entry
    );

    modport consumer (
        input write,
        input entry
    );
endinterface

//--- src/fmv_registers.sv
`timescale 1ns/10ps

module fmv_registers
    import vmpeg_bus_pkg::*;
    import vmpeg_stream_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic [ADDR_W:1]   address,
    input  logic [DATA_W-1:0] din,
    output logic [DATA_W-1:0] dout,
    input  logic              uds,
    input  logic              lds,
    input  logic              write_strobe,
    input  logic              cs,
    output logic              bus_ack,
    output logic              intreq,
    input  logic              intack,
    input  logic              release_strobe,
    input  header_event_s     released_entry,
    input  logic              timer_hit,
    output logic              dma_start,
    output logic              xfer_word,
    output logic [DATA_W-1:0] tcnt,
    output logic              trld
);
    logic [14:0]       reg_addr;
    logic              access;
    logic              wr_cycle;
    logic              rd_cycle;
    logic [DATA_W-1:0] ier;
    logic [DATA_W-1:0] ivec;
    interrupt_word_u   isr;
    logic [31:0]       timecode;
    logic [15:0]       tmpref;

    assign reg_addr = address[15:1];
    assign access   = cs && (uds || lds);

    // Data moves on the cycle where bus_ack is high
    assign wr_cycle = access && bus_ack && write_strobe;
    assign rd_cycle = access && bus_ack && !write_strobe;

    assign xfer_word = wr_cycle && (reg_addr == REG_XFER);
    assign trld      = wr_cycle && (reg_addr == REG_TRLD);
    assign dma_start = wr_cycle && (reg_addr == REG_SYSCMD) && (din == SYSCMD_DMA_START);

    assign intreq = (isr.word & ier) != '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_ack  <= 1'b0;
            ier      <= '0;
            ivec     <= '0;
            tcnt     <= TCNT_RESET;
            isr.word <= '0;
        end else begin
            // Toggles for as long as the access is held
            bus_ack <= access && !bus_ack;

            if (wr_cycle) begin
                case (reg_addr)
                    REG_IER:  ier <= din;
                    REG_TCNT: tcnt <= din;
                    REG_IVEC: ivec <= din;
                    default: ;
                endcase
            end

            // Reading the status clears it, new events still get through
            if (rd_cycle && reg_addr == REG_ISR) begin
                isr.word <= '0;
            end
            if (release_strobe) begin
                isr.flags.seq <= released_entry.seq;
                isr.flags.gop <= released_entry.gop;
                isr.flags.pic <= released_entry.pic;
            end
            if (timer_hit) begin
                isr.flags.tim <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (release_strobe) begin
            timecode <= released_entry.timecode;
            tmpref   <= released_entry.tmpref;
        end
    end

    always_comb begin
        dout = '0;
        case (reg_addr)
            REG_TIMECODE_HI: dout = timecode[31:16];
            REG_TIMECODE_LO: dout = timecode[15:0];
            REG_TMPREF:      dout = tmpref;
            REG_IER:         dout = ier;
            REG_ISR:         dout = isr.word;
            REG_TCNT:        dout = tcnt;
            REG_IVEC:        dout = ivec;
            default: ;
        endcase
        // Vector byte on both halves during the acknowledge cycle
        if (intack) begin
            dout = {ivec[10:3], ivec[10:3]};
        end
    end
endmodule

//--- src/dma_byte_stream.sv
`timescale 1ns/10ps

module dma_byte_stream
    import vmpeg_bus_pkg::*;
    import vmpeg_stream_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic [DATA_W-1:0] din,
    input  logic              ack,
    input  logic              dtc,
    input  logic              done_in,
    input  logic              dma_start,
    input  logic              xfer_word,
    output logic              req,
    output logic              rdy,
    output logic [7:0]        stream_byte,
    output logic              stream_byte_valid
);
    logic                      dma_active;
    logic                      word_strobe;
    logic                      buf_empty;
    logic [7:0]                byte_buf [BYTE_BUF_DEPTH];
    logic [BYTE_BUF_PTR_W-1:0] wr_ptr;
    logic [BYTE_BUF_PTR_W-1:0] rd_ptr;
    logic [BYTE_BUF_PTR_W:0]   fill;

    assign req = dma_active;
    assign rdy = dma_active;

    // DMA beats and XFER writes feed the same path
    assign word_strobe = (ack && dtc) || xfer_word;
    assign buf_empty   = (fill == '0);

    // With nothing queued the high byte goes straight out
    assign stream_byte       = buf_empty ? din[15:8] : byte_buf[rd_ptr];
    assign stream_byte_valid = word_strobe || !buf_empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            dma_active <= 1'b0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
        end else begin
            if (dma_start) begin
                dma_active <= 1'b1;
            end
            if (done_in && ack) begin
                dma_active <= 1'b0;
            end

            if (word_strobe && buf_empty) begin
                wr_ptr <= wr_ptr + 1'b1;
                fill   <= 1'b1;
            end else if (word_strobe) begin
                // Two bytes in, one out
                wr_ptr <= wr_ptr + 2'd2;
                rd_ptr <= rd_ptr + 1'b1;
                fill   <= fill + 1'b1;
            end else if (!buf_empty) begin
                rd_ptr <= rd_ptr + 1'b1;
                fill   <= fill - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (word_strobe && buf_empty) begin
            byte_buf[wr_ptr] <= din[7:0];
        end else if (word_strobe) begin
            byte_buf[wr_ptr]        <= din[15:8];
            byte_buf[wr_ptr + 1'b1] <= din[7:0];
        end
    end
endmodule

//--- src/stream_header_parser.sv
`timescale 1ns/10ps

module stream_header_parser
    import vmpeg_stream_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic [7:0]      stream_byte,
    input  logic            stream_byte_valid,
    header_event_if.producer events
);
    logic [2:0]          state;
    logic [1:0]          byte_idx;
    logic [TMPREF_W-1:0] pic_ref;
    logic [TMPREF_W-1:0] expected_ref;
    header_event_s       pending;
    logic                write_q;

    assign events.write = write_q;
    assign events.entry = pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= PS_IDLE;
            byte_idx     <= '0;
            expected_ref <= '0;
            pending      <= '0;
            write_q      <= 1'b0;
        end else begin
            write_q <= 1'b0;
            // Flags start over once an event has left
            if (write_q) begin
                pending.seq <= 1'b0;
                pending.gop <= 1'b0;
                pending.pic <= 1'b0;
            end

            if (stream_byte_valid) begin
                byte_idx <= byte_idx + 1'b1;
                case (state)
                    PS_IDLE: begin
                        if (stream_byte == START_PREFIX_ZERO) state <= PS_ZERO1;
                    end
                    PS_ZERO1: begin
                        state <= (stream_byte == START_PREFIX_ZERO) ? PS_ZERO2 : PS_IDLE;
                    end
                    PS_ZERO2: begin
                        // Further zeros are stuffing
                        if (stream_byte == START_PREFIX_ONE) begin
                            state <= PS_CODE;
                        end else if (stream_byte != START_PREFIX_ZERO) begin
                            state <= PS_IDLE;
                        end
                    end
                    PS_CODE: begin
                        byte_idx <= '0;
                        case (stream_byte)
                            CODE_SEQ: state <= PS_SEQ;
                            CODE_GOP: state <= PS_GOP;
                            CODE_PIC: state <= PS_PIC;
                            default:  state <= PS_IDLE;
                        endcase
                    end
                    PS_SEQ: begin
                        if (byte_idx == 2'(SEQ_HDR_BYTES - 1)) begin
                            pending.seq <= 1'b1;
                            state       <= PS_IDLE;
                        end
                    end
                    PS_GOP: begin
                        // Seconds and frames of the time code
                        case (byte_idx)
                            2'd1: pending.timecode[27:25] <= stream_byte[2:0];
                            2'd2: pending.timecode[24:17] <= stream_byte;
                            2'd3: pending.timecode[16] <= stream_byte[7];
                            default: ;
                        endcase
                        if (byte_idx == 2'(GOP_HDR_BYTES - 1)) begin
                            pending.gop  <= 1'b1;
                            expected_ref <= '0;
                            state        <= PS_IDLE;
                        end
                    end
                    PS_PIC: begin
                        case (byte_idx)
                            2'd0: pic_ref[TMPREF_W-1:2] <= stream_byte;
                            2'd1: pic_ref[1:0] <= stream_byte[7:6];
                            2'd2: begin
                                // Only an in-order reference updates tmpref
                                if (pic_ref == expected_ref) begin
                                    pending.tmpref <= {{(14 - TMPREF_W){1'b0}}, pic_ref, 2'b00};
                                    expected_ref   <= expected_ref + 1'b1;
                                end
                            end
                            default: ;
                        endcase
                        if (byte_idx == 2'(PIC_HDR_BYTES - 1)) begin
                            pending.pic <= 1'b1;
                            write_q     <= 1'b1;
                            state       <= PS_IDLE;
                        end
                    end
                    default: state <= PS_IDLE;
                endcase
            end
        end
    end
endmodule

//--- src/picture_event_queue.sv
`timescale 1ns/10ps

module picture_event_queue
    import vmpeg_stream_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          vsync,
    header_event_if.consumer events,
    output logic          release_strobe,
    output header_event_s released_entry
);
    header_event_s          mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_idx;
    logic [QUEUE_PTR_W-1:0] rd_idx;
    logic [QUEUE_PTR_W:0]   count;
    logic                   vsync_q;
    logic                   alt_edge;
    logic                   write_q;
    logic                   vsync_rise;
    logic                   head_ready;
    logic                   push;
    logic                   pop;

    assign vsync_rise = vsync && !vsync_q;
    // Full queue drops the write
    assign push = events.write && (count != (QUEUE_PTR_W + 1)'(QUEUE_DEPTH));
    // An entry written last cycle is not releasable yet
    assign head_ready = (count != '0) && !(write_q && count == 1);
    assign pop = vsync_rise && alt_edge && head_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_idx         <= '0;
            rd_idx         <= '0;
            count          <= '0;
            vsync_q        <= 1'b0;
            alt_edge       <= 1'b0;
            write_q        <= 1'b0;
            release_strobe <= 1'b0;
        end else begin
            vsync_q        <= vsync;
            write_q        <= push;
            release_strobe <= pop;
            if (vsync_rise) begin
                alt_edge <= !alt_edge;
            end
            if (push) begin
                wr_idx <= wr_idx + 1'b1;
            end
            if (pop) begin
                rd_idx <= rd_idx + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_idx] <= events.entry;
        end
        if (pop) begin
            released_entry <= mem[rd_idx];
        end
    end
endmodule

//--- src/system_timer.sv
`timescale 1ns/10ps

module system_timer
    import vmpeg_stream_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] tcnt,
    input  logic        trld,
    output logic        timer_hit
);
    logic [DCLK_CNT_W-1:0]          div_cnt;
    logic [15+TIMER_PRESCALE_BITS:0] tick_cnt;
    logic                           tick;

    assign tick = (div_cnt == DCLK_DIVIDER - 1'b1);

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt   <= '0;
            tick_cnt  <= '0;
            timer_hit <= 1'b0;
        end else begin
            timer_hit <= 1'b0;
            if (trld) begin
                // Reload restarts the whole period
                div_cnt  <= '0;
                tick_cnt <= '0;
            end else begin
                div_cnt <= tick ? '0 : div_cnt + 1'b1;
                if (tick) begin
                    // Period of (tcnt + 1) * 8 ticks
                    if (tick_cnt == {tcnt, {TIMER_PRESCALE_BITS{1'b1}}}) begin
                        timer_hit <= 1'b1;
                        tick_cnt  <= '0;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
            end
        end
    end
endmodule

//--- src/vmpeg_top.sv
`timescale 1ns/10ps

module vmpeg_top
    import vmpeg_bus_pkg::*;
    import vmpeg_stream_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic [ADDR_W:1]   address,
    input  logic [DATA_W-1:0] din,
    output logic [DATA_W-1:0] dout,
    input  logic              uds,
    input  logic              lds,
    input  logic              write_strobe,
    input  logic              cs,
    output logic              bus_ack,
    output logic              intreq,
    input  logic              intack,
    output logic              req,
    input  logic              ack,
    output logic              rdy,
    input  logic              dtc,
    input  logic              done_in,
    input  logic              vsync
);
    logic              dma_start;
    logic              xfer_word;
    logic [7:0]        stream_byte;
    logic              stream_byte_valid;
    logic              release_strobe;
    header_event_s     released_entry;
    logic              timer_hit;
    logic [DATA_W-1:0] tcnt;
    logic              trld;

    header_event_if event_bus ();

    fmv_registers i_registers (
        .clk(clk),
        .reset(reset),
        .address(address),
        .din(din),
        .dout(dout),
        .uds(uds),
        .lds(lds),
        .write_strobe(write_strobe),
        .cs(cs),
        .bus_ack(bus_ack),
        .intreq(intreq),
        .intack(intack),
        .release_strobe(release_strobe),
        .released_entry(released_entry),
        .timer_hit(timer_hit),
        .dma_start(dma_start),
        .xfer_word(xfer_word),
        .tcnt(tcnt),
        .trld(trld)
    );

    dma_byte_stream i_dma (
        .clk(clk),
        .reset(reset),
        .din(din),
        .ack(ack),
        .dtc(dtc),
        .done_in(done_in),
        .dma_start(dma_start),
        .xfer_word(xfer_word),
        .req(req),
        .rdy(rdy),
        .stream_byte(stream_byte),
        .stream_byte_valid(stream_byte_valid)
    );

    stream_header_parser i_parser (
        .clk(clk),
        .reset(reset),
        .stream_byte(stream_byte),
        .stream_byte_valid(stream_byte_valid),
        .events(event_bus.producer)
    );

    picture_event_queue i_queue (
        .clk(clk),
        .reset(reset),
        .vsync(vsync),
        .events(event_bus.consumer),
        .release_strobe(release_strobe),
        .released_entry(released_entry)
    );

    system_timer i_timer (
        .clk(clk),
        .reset(reset),
        .tcnt(tcnt),
        .trld(trld),
        .timer_hit(timer_hit)
    );
endmodule

//--- verification/vmpeg_tb.sv
`timescale 1ns/10ps

module vmpeg_tb
    import vmpeg_bus_pkg::*;
    import vmpeg_stream_pkg::*;
();
    // Ten times the timer test of about 6000 cycles
    localparam int TIMEOUT_CYCLES = 10 * 6000;
    // Compare value 0 gives eight ticks of 667 cycles
    localparam int TIMER_EARLIEST = 8 * 667;
    localparam int TIMER_LATEST   = 5400;
    localparam logic [15:0] IVEC_VALUE = 16'h0AB8;
    // IVEC bits 10 to 3 are 57 hex, on both halves
    localparam logic [15:0] IVEC_VECTOR = 16'h5757;

    // GOP time bytes, extra bits set to show they are ignored
    localparam logic [7:0]  GOP_BYTE1 = 8'hFD;
    localparam logic [7:0]  GOP_BYTE2 = 8'h9C;
    localparam logic [7:0]  GOP_BYTE3 = 8'hC1;
    // Timecode bits 27 to 25 are 101, 24 to 17 are 9C, bit 16 is 1
    localparam logic [15:0] EXP_TIMECODE_HI = 16'h0B39;
    localparam logic [15:0] EXP_TIMECODE_LO = 16'h0000;

    logic              clk;
    logic              reset;
    logic [ADDR_W:1]   address;
    logic [DATA_W-1:0] din;
    logic [DATA_W-1:0] dout;
    logic              uds;
    logic              lds;
    logic              write_strobe;
    logic              cs;
    logic              bus_ack;
    logic              intreq;
    logic              intack;
    logic              req;
    logic              ack;
    logic              rdy;
    logic              dtc;
    logic              done_in;
    logic              vsync;

    integer      seed;
    int          cycle_count = 0;
    int          waited;
    logic [7:0]  stream_q [$];
    logic [15:0] rdata;

    vmpeg_top i_dut (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT never finished", cycle_count);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    task automatic report_error(input string text);
        $display("%s", text);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected)
        else report_error($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    endtask

    // bus_ack must fall once cs is gone
    assert property (@(posedge clk) disable iff (reset) !cs |=> !bus_ack)
    else report_error("bus_ack still high one cycle after cs was released");

    assert property (@(posedge clk) disable iff (reset) req == rdy)
    else report_error("req and rdy disagree");

    function automatic logic [7:0] random_byte();
        logic [31:0] value;
        value = $random(seed);
        return value[7:0];
    endfunction

    task automatic access_bus(input logic [14:0] word_addr, input logic is_write,
                              input logic [15:0] wdata, output logic [15:0] data);
        @(posedge clk);
        address      <= {8'h00, word_addr};
        din          <= wdata;
        write_strobe <= is_write;
        cs           <= 1'b1;
        uds          <= 1'b1;
        lds          <= 1'b1;
        // Data moves on the edge after bus_ack is seen high
        do begin
            @(negedge clk);
        end while (!bus_ack);
        data = dout;
        @(posedge clk);
        cs           <= 1'b0;
        uds          <= 1'b0;
        lds          <= 1'b0;
        write_strobe <= 1'b0;
    endtask

    task automatic write_register(input logic [14:0] word_addr, input logic [15:0] wdata);
        logic [15:0] unused;
        access_bus(word_addr, 1'b1, wdata, unused);
    endtask

    task automatic read_register(input logic [14:0] word_addr, output logic [15:0] data);
        access_bus(word_addr, 1'b0, 16'h0000, data);
    endtask

    task automatic push_start_code(input logic [7:0] code);
        stream_q.push_back(START_PREFIX_ZERO);
        stream_q.push_back(START_PREFIX_ZERO);
        stream_q.push_back(START_PREFIX_ONE);
        stream_q.push_back(code);
    endtask

    task automatic push_seq_header();
        push_start_code(CODE_SEQ);
        stream_q.push_back(random_byte());
    endtask

    task automatic push_gop_header(input logic [7:0] b1, input logic [7:0] b2,
                                   input logic [7:0] b3);
        push_start_code(CODE_GOP);
        stream_q.push_back(random_byte());
        stream_q.push_back(b1);
        stream_q.push_back(b2);
        stream_q.push_back(b3);
    endtask

    // Temporal reference sits in byte 0 and the top of byte 1
    task automatic push_pic_header(input logic [9:0] tref);
        logic [7:0] filler;
        filler = random_byte();
        push_start_code(CODE_PIC);
        stream_q.push_back(tref[9:2]);
        stream_q.push_back({tref[1:0], filler[5:0]});
        stream_q.push_back(random_byte());
        stream_q.push_back(random_byte());
    endtask

    task automatic send_by_xfer();
        logic [7:0] hi;
        logic [7:0] lo;
        if (stream_q.size() % 2 != 0) begin
            stream_q.push_back(8'hFF);
        end
        while (stream_q.size() > 0) begin
            hi = stream_q.pop_front();
            lo = stream_q.pop_front();
            write_register(REG_XFER, {hi, lo});
        end
    endtask

    // One word per cycle with ack and dtc
    task automatic send_by_dma();
        logic [7:0] hi;
        logic [7:0] lo;
        if (stream_q.size() % 2 != 0) begin
            stream_q.push_back(8'hFF);
        end
        while (stream_q.size() > 0) begin
            hi = stream_q.pop_front();
            lo = stream_q.pop_front();
            @(posedge clk);
            ack <= 1'b1;
            dtc <= 1'b1;
            din <= {hi, lo};
        end
        @(posedge clk);
        ack <= 1'b0;
        dtc <= 1'b0;
    endtask

    task automatic pulse_vsync();
        @(posedge clk);
        vsync <= 1'b1;
        repeat (4) @(posedge clk);
        vsync <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    initial begin
        seed = 32'h74bb0ee8;
        reset        <= 1'b1;
        address      <= '0;
        din          <= '0;
        uds          <= 1'b0;
        lds          <= 1'b0;
        write_strobe <= 1'b0;
        cs           <= 1'b0;
        intack       <= 1'b0;
        ack          <= 1'b0;
        dtc          <= 1'b0;
        done_in      <= 1'b0;
        vsync        <= 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Register read-back and interrupt vector
        write_register(REG_IER, 16'h0107);
        write_register(REG_TCNT, 16'h1234);
        write_register(REG_IVEC, IVEC_VALUE);
        read_register(REG_IER, rdata);
        check_value("IER read-back", 16'h0107, rdata);
        read_register(REG_TCNT, rdata);
        check_value("TCNT read-back", 16'h1234, rdata);
        read_register(REG_IVEC, rdata);
        check_value("IVEC read-back", IVEC_VALUE, rdata);
        @(posedge clk);
        intack <= 1'b1;
        @(negedge clk);
        check_value("intack vector", IVEC_VECTOR, dout);
        @(posedge clk);
        intack <= 1'b0;

        // Header stream over XFER
        push_seq_header();
        push_gop_header(GOP_BYTE1, GOP_BYTE2, GOP_BYTE3);
        push_pic_header(10'd0);
        push_pic_header(10'd1);
        // Expected reference is 2 here
        push_pic_header(10'd5);
        send_by_xfer();

        repeat (2) pulse_vsync();
        @(negedge clk);
        check_value("intreq with ISR enabled", 16'd1, 16'(intreq));
        read_register(REG_ISR, rdata);
        check_value("ISR after first release", 16'h0007, rdata);
        @(negedge clk);
        check_value("intreq after ISR read", 16'd0, 16'(intreq));
        read_register(REG_TIMECODE_HI, rdata);
        check_value("timecode high", EXP_TIMECODE_HI, rdata);
        read_register(REG_TIMECODE_LO, rdata);
        check_value("timecode low", EXP_TIMECODE_LO, rdata);
        read_register(REG_TMPREF, rdata);
        check_value("tmpref of picture 0", 16'd0, rdata);

        write_register(REG_IER, 16'h0000);
        repeat (2) pulse_vsync();
        @(negedge clk);
        check_value("intreq with pic masked", 16'd0, 16'(intreq));
        write_register(REG_IER, 16'h0004);
        @(negedge clk);
        check_value("intreq with pic enabled", 16'd1, 16'(intreq));
        read_register(REG_TMPREF, rdata);
        check_value("tmpref of picture 1", 16'd4, rdata);
        read_register(REG_ISR, rdata);
        check_value("ISR after second release", 16'h0004, rdata);
        @(negedge clk);
        check_value("intreq after second ISR read", 16'd0, 16'(intreq));

        repeat (2) pulse_vsync();
        read_register(REG_TMPREF, rdata);
        check_value("tmpref after out-of-order picture", 16'd4, rdata);
        read_register(REG_ISR, rdata);
        check_value("ISR after third release", 16'h0004, rdata);

        // Same picture path through DMA
        write_register(REG_SYSCMD, SYSCMD_DMA_START);
        @(negedge clk);
        check_value("req after DMA start", 16'd1, 16'(req));
        check_value("rdy after DMA start", 16'd1, 16'(rdy));
        push_pic_header(10'd2);
        send_by_dma();
        @(posedge clk);
        done_in <= 1'b1;
        ack     <= 1'b1;
        @(posedge clk);
        done_in <= 1'b0;
        ack     <= 1'b0;
        @(negedge clk);
        check_value("req after done", 16'd0, 16'(req));
        repeat (2) pulse_vsync();
        read_register(REG_ISR, rdata);
        check_value("ISR after DMA picture", 16'h0004, rdata);
        read_register(REG_TMPREF, rdata);
        check_value("tmpref of DMA picture", 16'd8, rdata);

        // Timer with compare value 0
        write_register(REG_IER, 16'h0100);
        read_register(REG_ISR, rdata);
        write_register(REG_TCNT, 16'h0000);
        write_register(REG_TRLD, 16'h0000);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!intreq && waited <= TIMER_LATEST);
        assert (waited >= TIMER_EARLIEST && waited <= TIMER_LATEST)
        else report_error($sformatf("FAILED timer period: expected %0d to %0d cycles, actual %0d",
                                    TIMER_EARLIEST, TIMER_LATEST, waited));
        read_register(REG_ISR, rdata);
        check_value("ISR after timer", 16'h0100, rdata);
        @(negedge clk);
        check_value("intreq after timer ISR read", 16'd0, 16'(intreq));

        $display("Finished with no errors");
        $finish;
    end
endmodule

//--- tb.f
src/vmpeg_bus_pkg.sv
src/vmpeg_stream_pkg.sv
src/header_event_if.sv
src/fmv_registers.sv
src/dma_byte_stream.sv
src/stream_header_parser.sv
src/picture_event_queue.sv
src/system_timer.sv
src/vmpeg_top.sv
verification/vmpeg_tb.sv

//--- Makefile
# Verilator build and run of the vmpeg testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module vmpeg_tb -f tb.f

run: compile
	./obj_dir/Vvmpeg_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then exit 1; fi
	@grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
